// File: common/i3c_daa_consts.svh
`ifndef I3C_DAA_CONSTS_SVH
`define I3C_DAA_CONSTS_SVH

// Provisional ID as sent in ENTDAA
`define I3C_PID_W 48

// 48-bit ID followed by BCR and DCR
`define I3C_DEV_ID_W 64

`define I3C_BYTE_W 8
`define I3C_ADDR_W 7

// Must hold the value 64 itself
`define I3C_BIT_CNT_W 7

// Broadcast address
`define I3C_RSVD_ADDR 7'h7E

`endif

// File: common/i3c_daa_pkg.sv
`include "i3c_daa_consts.svh"

package i3c_daa_pkg;

  typedef logic [`I3C_PID_W-1:0] pid_t;
  typedef logic [`I3C_BYTE_W-1:0] char_t;
  typedef logic [`I3C_BYTE_W-1:0] byte_t;
  typedef logic [`I3C_ADDR_W-1:0] addr_t;
  typedef logic [`I3C_DEV_ID_W-1:0] dev_id_t;
  typedef logic [`I3C_BIT_CNT_W-1:0] bit_cnt_t;

  typedef enum logic [3:0] {
    Idle            = 4'h0,
    WaitStart       = 4'h1,
    ReceiveRsvdByte = 4'h2,
    AckRsvdByte     = 4'h3,
    SendNack        = 4'h4,
    SendID          = 4'h5,
    PrepareIDBit    = 4'h6,
    SendIDBit       = 4'h7,
    LostArbitration = 4'h8,
    ReceiveAddr     = 4'h9,
    AckAddr         = 4'ha,
    Done            = 4'hb,
    Error           = 4'hc
  } daa_state_e;

endpackage

// File: common/i3c_line_if.sv
interface i3c_line_if;

  logic scl_rise;
  logic scl_fall;
  logic sda;
  logic start_det;
  logic stop_det;

  modport mon (
    output scl_rise,
    output scl_fall,
    output sda,
    output start_det,
    output stop_det
  );

  modport eng (
    input scl_rise,
    input scl_fall,
    input sda
  );

  modport ctrl (
    input start_det,
    input stop_det
  );

endinterface

// File: common/i3c_xfer_if.sv
interface i3c_xfer_if;

  // Requests are levels, held until the matching done pulse
  logic                rx_req_byte;
  logic                tx_req_bit;
  logic                tx_value;

  i3c_daa_pkg::byte_t  rx_data;
  logic                rx_done;
  logic                tx_done;
  // Only meaningful while tx_done is high
  logic                arb_lost;

  modport ctrl (
    output rx_req_byte,
    output tx_req_bit,
    output tx_value,
    input  rx_data,
    input  rx_done,
    input  tx_done,
    input  arb_lost
  );

  modport eng (
    input  rx_req_byte,
    input  tx_req_bit,
    input  tx_value,
    output rx_data,
    output rx_done,
    output tx_done,
    output arb_lost
  );

endinterface

// File: rtl/bus_line_monitor.sv
module bus_line_monitor (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  i3c_line_if.mon    line
);

  logic scl_q, scl_prev_q;
  logic sda_q, sda_prev_q;
  logic scl_rise_q, scl_fall_q;
  logic start_q, stop_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Bus idles with both lines pulled up
      scl_q      <= 1'b1;
      scl_prev_q <= 1'b1;
      sda_q      <= 1'b1;
      sda_prev_q <= 1'b1;
      scl_rise_q <= 1'b0;
      scl_fall_q <= 1'b0;
      start_q    <= 1'b0;
      stop_q     <= 1'b0;
    end else begin
      scl_q      <= scl_i;
      scl_prev_q <= scl_q;
      sda_q      <= sda_i;
      sda_prev_q <= sda_q;
      scl_rise_q <= scl_q & ~scl_prev_q;
      scl_fall_q <= ~scl_q & scl_prev_q;
      // SDA edge with SCL stable high
      start_q    <= scl_q & scl_prev_q & sda_prev_q & ~sda_q;
      stop_q     <= scl_q & scl_prev_q & ~sda_prev_q & sda_q;
    end
  end

  assign line.scl_rise  = scl_rise_q;
  assign line.scl_fall  = scl_fall_q;
  assign line.sda       = sda_q;
  assign line.start_det = start_q;
  assign line.stop_det  = stop_q;

  a_start_stop_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(line.start_det && line.stop_det)
  );

endmodule

// File: rtl/bus_bit_engine.sv
module bus_bit_engine (
  input  logic       clk_i,
  input  logic       rst_ni,
  i3c_line_if.eng    line,
  i3c_xfer_if.eng    xfer,
  output logic       sda_oe_o
);

  i3c_daa_pkg::byte_t rx_shift_q;
  logic [2:0]         rx_cnt_q;
  logic               rx_done_q;

  logic               scl_low_q;
  logic               tx_active_q;
  logic               tx_sampled_q;
  logic               tx_val_q;
  logic               tx_done_q;
  logic               arb_lost_q;
  logic               sda_oe_q;
  logic               tx_load;

  // Tracks the SCL low phase after a fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_low_q <= 1'b0;
    end else if (line.scl_fall) begin
      scl_low_q <= 1'b1;
    end else if (line.scl_rise) begin
      scl_low_q <= 1'b0;
    end
  end

  // A request that arrives after the fall, still in the low phase, loads too,
  // so a bit chained right after tx_done is not one SCL period late
  assign tx_load = xfer.tx_req_bit & ~tx_active_q & ~tx_done_q
                 & (line.scl_fall | scl_low_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_cnt_q  <= '0;
      rx_done_q <= 1'b0;
    end else begin
      rx_done_q <= 1'b0;
      if (!xfer.rx_req_byte) begin
        rx_cnt_q <= '0;
      end else if (line.scl_rise) begin
        rx_cnt_q  <= rx_cnt_q + 3'd1;
        rx_done_q <= (rx_cnt_q == 3'd7);
      end
    end
  end

  // MSB first
  always_ff @(posedge clk_i) begin
    if (xfer.rx_req_byte && line.scl_rise) begin
      rx_shift_q <= {rx_shift_q[6:0], line.sda};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_active_q  <= 1'b0;
      tx_sampled_q <= 1'b0;
      tx_val_q     <= 1'b0;
      tx_done_q    <= 1'b0;
      arb_lost_q   <= 1'b0;
      sda_oe_q     <= 1'b0;
    end else begin
      tx_done_q <= 1'b0;
      if (tx_load) begin
        tx_active_q  <= 1'b1;
        tx_sampled_q <= 1'b0;
        tx_val_q     <= xfer.tx_value;
        sda_oe_q     <= ~xfer.tx_value;
        arb_lost_q   <= 1'b0;
      end else if (tx_active_q) begin
        if (line.scl_rise && !tx_sampled_q) begin
          tx_sampled_q <= 1'b1;
          // Released the line but someone else holds it low
          arb_lost_q   <= tx_val_q & ~line.sda;
        end else if (line.scl_fall && tx_sampled_q) begin
          tx_active_q <= 1'b0;
          sda_oe_q    <= 1'b0;
          tx_done_q   <= 1'b1;
        end
      end
    end
  end

  assign xfer.rx_data  = rx_shift_q;
  assign xfer.rx_done  = rx_done_q;
  assign xfer.tx_done  = tx_done_q;
  assign xfer.arb_lost = arb_lost_q;
  assign sda_oe_o      = sda_oe_q;

  a_req_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(xfer.rx_req_byte && xfer.tx_req_bit)
  );

  // The controller holds its bit request for as long as SDA is pulled low
  a_oe_in_tx: assert property (
    @(posedge clk_i) disable iff (!rst_ni) sda_oe_o |-> xfer.tx_req_bit
  );

endmodule

// File: entdaa/ccc_entdaa.sv
`include "i3c_daa_consts.svh"

module ccc_entdaa (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  i3c_daa_pkg::pid_t   id_i,
  input  i3c_daa_pkg::char_t  bcr_i,
  input  i3c_daa_pkg::char_t  dcr_i,

  input  logic                start_daa_i,
  output logic                done_daa_o,

  i3c_line_if.ctrl            line,
  i3c_xfer_if.ctrl            xfer,

  output i3c_daa_pkg::addr_t  address_o,
  output logic                address_valid_o
);

  i3c_daa_pkg::daa_state_e state_q, state_d;
  i3c_daa_pkg::bit_cnt_t   id_bit_cnt_q;
  i3c_daa_pkg::dev_id_t    device_id;

  logic load_id_cnt;
  logic tick_id_cnt;
  logic rsvd_byte_det;
  logic parity_ok;
  logic rx_req;
  logic tx_req;
  logic tx_val;

  assign device_id     = {id_i, bcr_i, dcr_i};
  // 7E with RnW set
  assign rsvd_byte_det = (xfer.rx_data == {`I3C_RSVD_ADDR, 1'b1});
  // Odd parity over address and parity bit
  assign parity_ok     = ^xfer.rx_data;
  assign done_daa_o    = (state_q == i3c_daa_pkg::Done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_bit_cnt_q <= '0;
    end else if (load_id_cnt) begin
      id_bit_cnt_q <= i3c_daa_pkg::bit_cnt_t'(`I3C_DEV_ID_W);
    end else if (tick_id_cnt) begin
      id_bit_cnt_q <= id_bit_cnt_q - 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      i3c_daa_pkg::Idle: begin
        if (start_daa_i) begin
          state_d = i3c_daa_pkg::WaitStart;
        end
      end
      i3c_daa_pkg::WaitStart: begin
        if (line.start_det) begin
          state_d = i3c_daa_pkg::ReceiveRsvdByte;
        end
      end
      i3c_daa_pkg::ReceiveRsvdByte: begin
        if (xfer.rx_done) begin
          state_d = rsvd_byte_det ? i3c_daa_pkg::AckRsvdByte : i3c_daa_pkg::SendNack;
        end
      end
      i3c_daa_pkg::AckRsvdByte: begin
        if (xfer.tx_done) begin
          state_d = i3c_daa_pkg::SendID;
        end
      end
      i3c_daa_pkg::SendNack: begin
        if (xfer.tx_done) begin
          state_d = i3c_daa_pkg::Error;
        end
      end
      i3c_daa_pkg::SendID: begin
        state_d = i3c_daa_pkg::PrepareIDBit;
      end
      i3c_daa_pkg::PrepareIDBit: begin
        if (id_bit_cnt_q != '0) begin
          state_d = i3c_daa_pkg::SendIDBit;
        end
      end
      i3c_daa_pkg::SendIDBit: begin
        if (xfer.tx_done) begin
          if (xfer.arb_lost) begin
            state_d = i3c_daa_pkg::LostArbitration;
          end else if (id_bit_cnt_q == '0) begin
            state_d = i3c_daa_pkg::ReceiveAddr;
          end else begin
            state_d = i3c_daa_pkg::PrepareIDBit;
          end
        end
      end
      i3c_daa_pkg::LostArbitration: begin
        state_d = i3c_daa_pkg::Error;
      end
      i3c_daa_pkg::ReceiveAddr: begin
        if (xfer.rx_done) begin
          state_d = parity_ok ? i3c_daa_pkg::AckAddr : i3c_daa_pkg::SendNack;
        end
      end
      i3c_daa_pkg::AckAddr: begin
        if (xfer.tx_done) begin
          state_d = i3c_daa_pkg::Done;
        end
      end
      i3c_daa_pkg::Done: begin
        state_d = i3c_daa_pkg::Idle;
      end
      default: begin
        // Error holds until STOP
        state_d = state_q;
      end
    endcase
  end

  always_comb begin
    rx_req          = 1'b0;
    tx_req          = 1'b0;
    tx_val          = 1'b0;
    load_id_cnt     = 1'b0;
    tick_id_cnt     = 1'b0;
    address_o       = '0;
    address_valid_o = 1'b0;
    unique case (state_q)
      i3c_daa_pkg::ReceiveRsvdByte: begin
        rx_req = 1'b1;
      end
      i3c_daa_pkg::AckRsvdByte: begin
        tx_req = 1'b1;
      end
      i3c_daa_pkg::SendNack: begin
        tx_req = 1'b1;
        tx_val = 1'b1;
      end
      i3c_daa_pkg::SendID: begin
        load_id_cnt = 1'b1;
      end
      i3c_daa_pkg::PrepareIDBit: begin
        tick_id_cnt = 1'b1;
      end
      i3c_daa_pkg::SendIDBit: begin
        // Counter already decremented, so 63 selects the MSB
        tx_req = 1'b1;
        tx_val = device_id[id_bit_cnt_q[5:0]];
      end
      i3c_daa_pkg::ReceiveAddr: begin
        rx_req = 1'b1;
        if (xfer.rx_done && parity_ok) begin
          address_valid_o = 1'b1;
          address_o       = xfer.rx_data[7:1];
        end
      end
      i3c_daa_pkg::AckAddr: begin
        tx_req = 1'b1;
      end
      default: begin
        rx_req = 1'b0;
      end
    endcase
  end

  assign xfer.rx_req_byte = rx_req;
  assign xfer.tx_req_bit  = tx_req;
  assign xfer.tx_value    = tx_val;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= i3c_daa_pkg::Idle;
    end else if (line.stop_det) begin
      // STOP ends the procedure wherever it stands
      state_q <= i3c_daa_pkg::Done;
    end else begin
      state_q <= state_d;
    end
  end

  a_addr_valid_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    address_valid_o |-> (state_q == i3c_daa_pkg::ReceiveAddr) && xfer.rx_done
  );

endmodule

// File: rtl/i3c_daa_top.sv
module i3c_daa_top (
  input  logic                clk_i,
  input  logic                rst_ni,

  input  logic                scl_i,
  input  logic                sda_i,

  input  i3c_daa_pkg::pid_t   id_i,
  input  i3c_daa_pkg::char_t  bcr_i,
  input  i3c_daa_pkg::char_t  dcr_i,

  input  logic                start_daa_i,
  output logic                done_daa_o,

  // Open-drain pull-down enable for SDA
  output logic                sda_oe_o,

  output i3c_daa_pkg::addr_t  address_o,
  output logic                address_valid_o
);

  i3c_line_if line_bus ();
  i3c_xfer_if xfer_bus ();

  bus_line_monitor u_monitor (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .line   (line_bus.mon)
  );

  bus_bit_engine u_bit_engine (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .line     (line_bus.eng),
    .xfer     (xfer_bus.eng),
    .sda_oe_o (sda_oe_o)
  );

  ccc_entdaa u_entdaa (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .id_i            (id_i),
    .bcr_i           (bcr_i),
    .dcr_i           (dcr_i),
    .start_daa_i     (start_daa_i),
    .done_daa_o      (done_daa_o),
    .line            (line_bus.ctrl),
    .xfer            (xfer_bus.ctrl),
    .address_o       (address_o),
    .address_valid_o (address_valid_o)
  );

endmodule

// File: sim/tb_i3c_daa.sv
module tb_i3c_daa;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  // System clocks per SCL phase
  localparam int PHASE = 8;
  localparam int WAIT_LIMIT = 400;
  localparam logic [7:0] RSVD_RD = 8'hFD;
  localparam logic [7:0] RSVD_WR = 8'hFC;

  logic clk;
  logic rst_n;
  logic scl;
  logic sda_drv;
  logic sda;
  i3c_daa_pkg::pid_t id;
  i3c_daa_pkg::char_t bcr;
  i3c_daa_pkg::char_t dcr;
  logic start_daa;
  logic done_daa;
  logic sda_oe;
  i3c_daa_pkg::addr_t address;
  logic address_valid;

  int unsigned done_cnt = 0;
  int unsigned addr_cnt = 0;
  int unsigned oe_cnt = 0;
  logic [6:0] addr_seen;

  // Open-drain bus, wired-AND of controller and target
  assign sda = sda_drv & ~sda_oe;

  i3c_daa_top uut (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .scl_i           (scl),
    .sda_i           (sda),
    .id_i            (id),
    .bcr_i           (bcr),
    .dcr_i           (dcr),
    .start_daa_i     (start_daa),
    .done_daa_o      (done_daa),
    .sda_oe_o        (sda_oe),
    .address_o       (address),
    .address_valid_o (address_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Event counters, sampled mid-cycle
  always @(negedge clk) begin
    if (done_daa) begin
      done_cnt = done_cnt + 1;
    end
    if (address_valid) begin
      addr_cnt = addr_cnt + 1;
      addr_seen = address;
    end
    if (sda_oe) begin
      oe_cnt = oe_cnt + 1;
    end
  end

  task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
    end
    #1;
  endtask

  task automatic wait_done(input int unsigned target);
    int cycles;
    cycles = 0;
    while (done_cnt < target && cycles < WAIT_LIMIT) begin
      step(1);
      cycles++;
    end
    if (done_cnt < target) begin
      $display("Timeout at %0t ns: done_daa_o did not pulse while waiting in wait_done",
               $time);
      $display("TEST FAILED");
      $fatal(1, "wait_done timed out");
    end
  endtask

  // Bit tasks start by pulling SCL low and end with SCL high
  task automatic send_bit(input logic b);
    scl = 1'b0;
    step(2);
    sda_drv = b;
    step(PHASE - 2);
    scl = 1'b1;
    step(PHASE);
  endtask

  task automatic read_bit(output logic b);
    scl = 1'b0;
    step(2);
    sda_drv = 1'b1;
    step(PHASE - 2);
    scl = 1'b1;
    step(PHASE / 2);
    b = sda;
    step(PHASE / 2);
  endtask

  task automatic send_byte(input logic [7:0] data);
    for (int i = 7; i >= 0; i--) begin
      send_bit(data[i]);
    end
  endtask

  task automatic bus_start();
    sda_drv = 1'b0;
    step(PHASE);
  endtask

  task automatic bus_rstart();
    scl = 1'b0;
    step(2);
    sda_drv = 1'b1;
    step(PHASE - 2);
    scl = 1'b1;
    step(PHASE);
    sda_drv = 1'b0;
    step(PHASE);
  endtask

  task automatic bus_stop();
    scl = 1'b0;
    step(2);
    sda_drv = 1'b0;
    step(PHASE - 2);
    scl = 1'b1;
    step(PHASE);
    sda_drv = 1'b1;
    step(PHASE);
  endtask

  function automatic logic [7:0] make_addr_byte(input logic [6:0] a, input logic good);
    // Odd parity over all 8 bits when good
    make_addr_byte = {a, good ? ~^a : ^a};
  endfunction

  task automatic pick_ids();
    id[47:32] = 16'($urandom());
    id[31:0] = $urandom();
    bcr = 8'($urandom());
    dcr = 8'($urandom());
  endtask

  // START, CCC start request, then Sr into the reserved byte
  task automatic begin_daa();
    bus_start();
    start_daa = 1'b1;
    step(1);
    start_daa = 1'b0;
    bus_rstart();
  endtask

  task automatic run_id_phase(input logic [63:0] dev, input string name);
    logic b;
    begin_daa();
    send_byte(RSVD_RD);
    read_bit(b);
    check_eq(b, 0, $sformatf("%s: ACK of reserved byte", name));
    for (int k = 63; k >= 0; k--) begin
      read_bit(b);
      check_eq(b, dev[k], $sformatf("%s: ID bit %0d", name, k));
    end
  endtask

  task automatic test_reset_idle();
    for (int i = 0; i <= 10; i++) begin
      check_eq(sda_oe, 0, "sda_oe_o after reset");
      check_eq(done_daa, 0, "done_daa_o after reset");
      check_eq(address_valid, 0, "address_valid_o after reset");
      step(1);
    end
  endtask

  task automatic test_full_entdaa(input string name);
    logic [63:0] dev;
    logic [6:0] addr;
    logic b;
    int unsigned done_base;
    int unsigned addr_base;
    pick_ids();
    dev = {id, bcr, dcr};
    addr = 7'($urandom());
    done_base = done_cnt;
    addr_base = addr_cnt;
    run_id_phase(dev, name);
    send_byte(make_addr_byte(addr, 1'b1));
    read_bit(b);
    check_eq(b, 0, $sformatf("%s: ACK of address", name));
    check_eq(addr_cnt, addr_base + 1, $sformatf("%s: address_valid_o pulses", name));
    check_eq(addr_seen, addr, $sformatf("%s: address_o", name));
    // Next ENTDAA round, no other target answers
    bus_rstart();
    wait_done(done_base + 1);
    step(20);
    check_eq(done_cnt, done_base + 1, $sformatf("%s: done_daa_o pulses", name));
    bus_stop();
    wait_done(done_base + 2);
  endtask

  task automatic test_wrong_rsvd();
    logic b;
    int unsigned done_base;
    int unsigned oe_base;
    pick_ids();
    done_base = done_cnt;
    begin_daa();
    oe_base = oe_cnt;
    send_byte(RSVD_WR);
    read_bit(b);
    check_eq(b, 1, "NACK of reserved byte with RnW 0");
    for (int i = 0; i < 8; i++) begin
      read_bit(b);
      check_eq(b, 1, "released SDA after NACK");
    end
    check_eq(oe_cnt, oe_base, "sda_oe_o pulses after NACK");
    bus_stop();
    wait_done(done_base + 1);
  endtask

  task automatic test_bad_parity();
    logic [63:0] dev;
    logic b;
    int unsigned done_base;
    int unsigned addr_base;
    pick_ids();
    dev = {id, bcr, dcr};
    done_base = done_cnt;
    addr_base = addr_cnt;
    run_id_phase(dev, "bad parity");
    send_byte(make_addr_byte(7'($urandom()), 1'b0));
    read_bit(b);
    check_eq(b, 1, "NACK of address with bad parity");
    check_eq(addr_cnt, addr_base, "address_valid_o with bad parity");
    bus_stop();
    wait_done(done_base + 1);
  endtask

  task automatic test_arbitration();
    logic [63:0] dev;
    logic b;
    int lose;
    int unsigned done_base;
    int unsigned addr_base;
    int unsigned oe_base;
    pick_ids();
    // At least one released bit to lose on
    dcr[0] = 1'b1;
    dev = {id, bcr, dcr};
    lose = 0;
    for (int k = 0; k < 64; k++) begin
      if (dev[k]) begin
        lose = k;
      end
    end
    done_base = done_cnt;
    addr_base = addr_cnt;
    begin_daa();
    send_byte(RSVD_RD);
    read_bit(b);
    check_eq(b, 0, "arbitration: ACK of reserved byte");
    for (int k = 63; k > lose; k--) begin
      read_bit(b);
      check_eq(b, 0, $sformatf("arbitration: ID bit %0d", k));
    end
    // Another target holds SDA low here
    send_bit(1'b0);
    oe_base = oe_cnt;
    for (int k = lose - 1; k >= 0; k--) begin
      read_bit(b);
      check_eq(b, 1, $sformatf("arbitration: released ID bit %0d", k));
    end
    send_byte(make_addr_byte(7'($urandom()), 1'b1));
    read_bit(b);
    check_eq(b, 1, "arbitration: address not acknowledged");
    check_eq(oe_cnt, oe_base, "arbitration: sda_oe_o after loss");
    check_eq(addr_cnt, addr_base, "arbitration: address_valid_o after loss");
    bus_stop();
    wait_done(done_base + 1);
  endtask

  initial begin
    void'($urandom(1));
    clk = 1'b0;
    rst_n = 1'b0;
    scl = 1'b1;
    sda_drv = 1'b1;
    id = '0;
    bcr = '0;
    dcr = '0;
    start_daa = 1'b0;
    step(2);
    rst_n = 1'b1;
    test_reset_idle();
    test_full_entdaa("full ENTDAA");
    test_wrong_rsvd();
    test_bad_parity();
    test_arbitration();
    test_full_entdaa("second ENTDAA");
    $display("TEST PASSED");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * 50000);
    $display("Timeout: the simulation ran past its overall time limit");
    $display("TEST FAILED");
    $fatal(1, "overall time limit reached");
  end

endmodule

// File: tb.f
+incdir+common
common/i3c_daa_pkg.sv
common/i3c_line_if.sv
common/i3c_xfer_if.sv
rtl/bus_line_monitor.sv
rtl/bus_bit_engine.sv
entdaa/ccc_entdaa.sv
rtl/i3c_daa_top.sv
sim/tb_i3c_daa.sv

// File: Makefile
TOP := tb_i3c_daa

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module i3c_daa_top

clean:
	rm -rf obj_dir
